//--- sim.f
offload_pkg.sv
mul_pkg.sv
offload_if.sv
spill_register.sv
resp_arbiter.sv
mul_ctrl.sv
mul_counter.sv
mul_datapath.sv
int_mul_unit.sv
offload_cc.sv
tb_offload_cc.sv

//--- run.sh
#!/bin/sh
# Build and run the offload core complex testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_offload_cc -f sim.f -o tb_offload_cc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_offload_cc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  echo "Simulation reported errors, see $LOG"
  exit 1
fi

echo "Simulation finished without reported errors"
exit 0

//--- tb_offload_cc.sv
/* Offload core complex testbench
   Local and shared traffic with a shared-unit model, scoreboard and back-pressure */
`timescale 1ns/100ps

module tb_offload_cc;
  import offload_pkg::*;

  localparam int NUM_REQ        = 200;
  localparam int NUM_DIRECTED   = 12;
  localparam int NUM_IDS        = 1 << ID_WIDTH;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_REQ * 40 + 1000;

  // Local unit corner cases with the unknown ops 2 and 3 at the end
  localparam logic [DATA_WIDTH-1:0] DIR_A [NUM_DIRECTED] = '{
    32'h0, 32'h0, 32'hffffffff, 32'hffffffff, 32'hffffffff, 32'hffffffff,
    32'h1, 32'h80000000, 32'h12345678, 32'h12345678, 32'hdeadbeef, 32'hcafef00d
  };
  localparam logic [DATA_WIDTH-1:0] DIR_B [NUM_DIRECTED] = '{
    32'h0, 32'h0, 32'hffffffff, 32'hffffffff, 32'h1, 32'h1,
    32'hffffffff, 32'h2, 32'h9abcdef0, 32'h9abcdef0, 32'h2, 32'h3
  };
  localparam logic [OP_WIDTH-1:0] DIR_OP [NUM_DIRECTED] = '{
    2'd0, 2'd1, 2'd0, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd0, 2'd1, 2'd2, 2'd3
  };

  logic                  clk_i = 1'b0;
  logic                  rst_i;
  logic                  req_valid_i, req_ready_o;
  logic [ID_WIDTH-1:0]   req_id_i;
  logic [OP_WIDTH-1:0]   req_op_i;
  logic [DATA_WIDTH-1:0] req_arga_i, req_argb_i;
  logic                  req_target_i;
  logic                  resp_valid_o, resp_ready_i;
  logic [ID_WIDTH-1:0]   resp_id_o;
  logic [DATA_WIDTH-1:0] resp_data_o;
  logic                  resp_error_o;
  logic                  sh_req_valid_o, sh_req_ready_i;
  logic [ID_WIDTH-1:0]   sh_req_id_o;
  logic [OP_WIDTH-1:0]   sh_req_op_o;
  logic [DATA_WIDTH-1:0] sh_req_arga_o, sh_req_argb_o;
  logic                  sh_resp_valid_i, sh_resp_ready_o;
  logic [ID_WIDTH-1:0]   sh_resp_id_i;
  logic [DATA_WIDTH-1:0] sh_resp_data_i;
  logic                  sh_resp_error_i;

  // Stimulus side state
  int                    cycle = 0;
  int                    issued;
  logic                  timed_out;
  logic [31:0]           lcg_state;
  logic                  req_fire, sh_resp_fire;
  logic [ID_WIDTH-1:0]   sh_id_q[$];
  logic [DATA_WIDTH-1:0] sh_data_q[$];
  int                    sh_due_q[$];

  // Scoreboard by id
  // An id is in flight while issue_cnt is one ahead of retire_cnt
  int                    issue_cnt  [NUM_IDS];
  int                    retire_cnt [NUM_IDS];
  logic                  exp_target [NUM_IDS];
  logic [OP_WIDTH-1:0]   exp_op     [NUM_IDS];
  logic [DATA_WIDTH-1:0] exp_arga   [NUM_IDS];
  logic [DATA_WIDTH-1:0] exp_argb   [NUM_IDS];
  logic [DATA_WIDTH-1:0] exp_data   [NUM_IDS];
  logic                  exp_error  [NUM_IDS];

  // Compare side state
  int                    val_errors = 0;
  int                    proto_errors = 0;
  int                    resp_count = 0;
  logic                  hold_pending = 1'b0;
  logic [ID_WIDTH-1:0]   hold_id;
  logic [DATA_WIDTH-1:0] hold_data;
  logic                  hold_error;

  offload_cc UUT (.*);

  always #4 clk_i = ~clk_i;

  // ----------------------------------------
  // Random numbers and reference model
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    int r;
    r = int'(lcg_next() >> 16);
    return r % n;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] random_operand();
    logic [31:0] hi;
    logic [31:0] lo;
    int          pick;
    pick = rand_below(8);
    hi   = lcg_next();
    lo   = lcg_next();
    case (pick)
      0: random_operand = '1;
      1: random_operand = '0;
      default: random_operand = {hi[31:16], lo[31:16]};
    endcase
  endfunction

  // Error bit on top of the data word
  function automatic logic [DATA_WIDTH:0] expected_resp(
    input logic                  target,
    input logic [OP_WIDTH-1:0]   op,
    input logic [DATA_WIDTH-1:0] a,
    input logic [DATA_WIDTH-1:0] b
  );
    logic [2*DATA_WIDTH-1:0] prod;
    prod = {{DATA_WIDTH{1'b0}}, a} * {{DATA_WIDTH{1'b0}}, b};
    if (target == TARGET_SHARED) begin
      // Shared unit model answers with the XOR of its operands
      return {1'b0, a ^ b};
    end else if (op == 2'd0) begin
      return {1'b0, prod[DATA_WIDTH-1:0]};
    end else if (op == 2'd1) begin
      return {1'b0, prod[2*DATA_WIDTH-1:DATA_WIDTH]};
    end
    return {1'b1, {DATA_WIDTH{1'b0}}};
  endfunction

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  task automatic issue_request();
    logic [ID_WIDTH-1:0]   id;
    logic                  found;
    int                    start;
    logic [DATA_WIDTH:0]   exp;
    found = 1'b0;
    start = rand_below(NUM_IDS);
    for (int k = 0; k < NUM_IDS; k++) begin
      if (!found && issue_cnt[ID_WIDTH'(start + k)] == retire_cnt[ID_WIDTH'(start + k)]) begin
        id    = ID_WIDTH'(start + k);
        found = 1'b1;
      end
    end
    if (found) begin
      if (issued < NUM_DIRECTED) begin
        req_target_i = TARGET_LOCAL;
        req_op_i     = DIR_OP[issued];
        req_arga_i   = DIR_A[issued];
        req_argb_i   = DIR_B[issued];
      end else begin
        req_target_i = (rand_below(2) == 1) ? TARGET_SHARED : TARGET_LOCAL;
        req_op_i     = (rand_below(8) == 0) ? OP_WIDTH'(2 + rand_below(2))
                                             : OP_WIDTH'(rand_below(2));
        req_arga_i   = random_operand();
        req_argb_i   = random_operand();
      end
      req_id_i       = id;
      req_valid_i    = 1'b1;
      exp            = expected_resp(req_target_i, req_op_i, req_arga_i, req_argb_i);
      exp_target[id] = req_target_i;
      exp_op[id]     = req_op_i;
      exp_arga[id]   = req_arga_i;
      exp_argb[id]   = req_argb_i;
      exp_error[id]  = exp[DATA_WIDTH];
      exp_data[id]   = exp[DATA_WIDTH-1:0];
      issue_cnt[id]  = issue_cnt[id] + 1;
    end
  endtask

  task automatic drive_core_side();
    if (req_valid_i && req_fire) begin
      req_valid_i = 1'b0;
      issued++;
    end
    if (!req_valid_i && issued < NUM_REQ && rand_below(4) != 0) begin
      issue_request();
    end
    // Every other window of 150 cycles drains the output slowly
    if ((cycle / 150) % 2 == 1) begin
      resp_ready_i = (rand_below(6) == 0);
    end else begin
      resp_ready_i = (rand_below(4) != 0);
    end
  endtask

  // Shared unit model answering in order after a random delay
  task automatic drive_shared_unit();
    if (sh_resp_valid_i && sh_resp_fire) begin
      sh_resp_valid_i = 1'b0;
      void'(sh_id_q.pop_front());
      void'(sh_data_q.pop_front());
      void'(sh_due_q.pop_front());
    end
    if (!sh_resp_valid_i && sh_id_q.size() > 0 && sh_due_q[0] <= cycle) begin
      sh_resp_valid_i = 1'b1;
      sh_resp_id_i    = sh_id_q[0];
      sh_resp_data_i  = sh_data_q[0];
      sh_resp_error_i = 1'b0;
    end
    sh_req_ready_i = (rand_below(4) != 0);
  endtask

  // Handshakes that the next rising edge completes
  task automatic sample_handshakes();
    req_fire     = req_valid_i & req_ready_o;
    sh_resp_fire = sh_resp_valid_i & sh_resp_ready_o;
    if (sh_req_valid_o && sh_req_ready_i) begin
      sh_id_q.push_back(sh_req_id_o);
      sh_data_q.push_back(sh_req_arga_o ^ sh_req_argb_o);
      sh_due_q.push_back(cycle + 1 + rand_below(8));
    end
  endtask

  task automatic print_counts(input int end_errors);
    $display("Errors: value %0d, protocol %0d, end of run %0d; responses %0d of %0d",
             val_errors, proto_errors, end_errors, resp_count, NUM_REQ);
  endtask

  // ----------------------------------------
  // Main stimulus process
  // ----------------------------------------
  initial begin : stimulus
    int tail_left;
    int end_errors;
    rst_i           = 1'b1;
    req_valid_i     = 1'b0;
    req_id_i        = '0;
    req_op_i        = '0;
    req_arga_i      = '0;
    req_argb_i      = '0;
    req_target_i    = TARGET_LOCAL;
    resp_ready_i    = 1'b0;
    sh_req_ready_i  = 1'b0;
    sh_resp_valid_i = 1'b0;
    sh_resp_id_i    = '0;
    sh_resp_data_i  = '0;
    sh_resp_error_i = 1'b0;
    lcg_state       = 32'd97286;
    issued          = 0;
    timed_out       = 1'b0;
    req_fire        = 1'b0;
    sh_resp_fire    = 1'b0;
    tail_left       = 20;
    end_errors      = 0;
    foreach (issue_cnt[i]) begin
      issue_cnt[i]  = 0;
      retire_cnt[i] = 0;
    end
    while (!timed_out && tail_left > 0) begin
      @(posedge clk_i);
      #1;
      cycle++;
      if (cycle >= TIMEOUT_CYCLES) begin
        timed_out = 1'b1;
      end else if (cycle >= RESET_CYCLES) begin
        rst_i = 1'b0;
        drive_core_side();
        drive_shared_unit();
        if (issued >= NUM_REQ && resp_count >= NUM_REQ) begin
          tail_left--;
        end
      end
      @(negedge clk_i);
      sample_handshakes();
    end
    if (timed_out) begin
      $display("Timeout at cycle %0d with %0d of %0d responses", cycle, resp_count, NUM_REQ);
    end
    foreach (issue_cnt[i]) begin
      assert (issue_cnt[i] == retire_cnt[i]) else begin
        end_errors++;
        $display("Request id %0d never got its response", i);
      end
    end
    print_counts(end_errors);
    if (!timed_out && val_errors + proto_errors + end_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
    assert (act === exp) else begin
      val_errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic expect_low(input string name, input logic value);
    assert (value === 1'b0) else begin
      val_errors++;
      $display("FAIL t=%0t %s expected 0 got %b", $time, name, value);
    end
  endtask

  task automatic check_shared_request();
    logic [ID_WIDTH-1:0] id;
    id = sh_req_id_o;
    assert (issue_cnt[id] == retire_cnt[id] + 1 && exp_target[id] == TARGET_SHARED)
    else begin
      proto_errors++;
      $display("Id %0d reached the shared port at %0t without a shared request", id, $time);
    end
    compare_word("sh_req_op_o", DATA_WIDTH'(exp_op[id]), DATA_WIDTH'(sh_req_op_o));
    compare_word("sh_req_arga_o", exp_arga[id], sh_req_arga_o);
    compare_word("sh_req_argb_o", exp_argb[id], sh_req_argb_o);
  endtask

  task automatic check_response_port();
    logic [ID_WIDTH-1:0] id;
    id = resp_id_o;
    // A stalled response must hold still
    if (hold_pending) begin
      assert (resp_valid_o) else begin
        proto_errors++;
        $display("resp_valid_o dropped at %0t before the response transferred", $time);
      end
      compare_word("resp_id_o", DATA_WIDTH'(hold_id), DATA_WIDTH'(resp_id_o));
      compare_word("resp_data_o", hold_data, resp_data_o);
      compare_word("resp_error_o", DATA_WIDTH'(hold_error), DATA_WIDTH'(resp_error_o));
    end
    if (resp_valid_o && resp_ready_i) begin
      assert (issue_cnt[id] == retire_cnt[id] + 1) else begin
        proto_errors++;
        $display("Response id %0d at %0t matches no outstanding request", id, $time);
      end
      if (issue_cnt[id] == retire_cnt[id] + 1) begin
        compare_word("resp_data_o", exp_data[id], resp_data_o);
        compare_word("resp_error_o", DATA_WIDTH'(exp_error[id]), DATA_WIDTH'(resp_error_o));
        retire_cnt[id] = retire_cnt[id] + 1;
      end
      resp_count++;
    end
    hold_pending = resp_valid_o & ~resp_ready_i;
    hold_id      = resp_id_o;
    hold_data    = resp_data_o;
    hold_error   = resp_error_o;
  endtask

  always @(negedge clk_i) begin
    if (cycle > 0) begin
      // Through reset and the first edge after it
      if (cycle <= RESET_CYCLES + 1) begin
        expect_low("resp_valid_o", resp_valid_o);
        expect_low("sh_req_valid_o", sh_req_valid_o);
        expect_low("sh_resp_ready_o", sh_resp_ready_o);
      end
      if (cycle <= RESET_CYCLES) begin
        expect_low("req_ready_o", req_ready_o);
      end else if (cycle == RESET_CYCLES + 1) begin
        assert (req_ready_o === 1'b1) else begin
          val_errors++;
          $display("FAIL t=%0t req_ready_o expected 1 got %b", $time, req_ready_o);
        end
      end
      if (sh_req_valid_o && sh_req_ready_i) begin
        check_shared_request();
      end
      check_response_port();
    end
  end

endmodule

//--- offload_cc.sv
/* Offload core complex
   Cuts the request path, steers to local multiplier or shared unit,
   merges responses and cuts the response path */
`timescale 1ns/100ps

module offload_cc (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Core request
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [offload_pkg::ID_WIDTH-1:0]    req_id_i,
  input  logic [offload_pkg::OP_WIDTH-1:0]    req_op_i,
  input  logic [offload_pkg::DATA_WIDTH-1:0]  req_arga_i,
  input  logic [offload_pkg::DATA_WIDTH-1:0]  req_argb_i,
  input  logic                                req_target_i,
  // Core response
  output logic                                resp_valid_o,
  input  logic                                resp_ready_i,
  output logic [offload_pkg::ID_WIDTH-1:0]    resp_id_o,
  output logic [offload_pkg::DATA_WIDTH-1:0]  resp_data_o,
  output logic                                resp_error_o,
  // Shared unit request
  output logic                                sh_req_valid_o,
  input  logic                                sh_req_ready_i,
  output logic [offload_pkg::ID_WIDTH-1:0]    sh_req_id_o,
  output logic [offload_pkg::OP_WIDTH-1:0]    sh_req_op_o,
  output logic [offload_pkg::DATA_WIDTH-1:0]  sh_req_arga_o,
  output logic [offload_pkg::DATA_WIDTH-1:0]  sh_req_argb_o,
  // Shared unit response
  input  logic                                sh_resp_valid_i,
  output logic                                sh_resp_ready_o,
  input  logic [offload_pkg::ID_WIDTH-1:0]    sh_resp_id_i,
  input  logic [offload_pkg::DATA_WIDTH-1:0]  sh_resp_data_i,
  input  logic                                sh_resp_error_i
);
  import offload_pkg::*;

  acc_req_t  req_d, req_q;
  logic      req_q_valid, req_q_ready;
  logic      to_local, to_shared;
  acc_resp_t arb_resp, resp_q;
  logic      arb_valid, arb_ready;

  acc_req_if  mul_req ();
  acc_resp_if mul_resp ();
  acc_resp_if sh_resp ();

  // ----------------------------------------
  // Request path
  // ----------------------------------------
  assign req_d.id     = req_id_i;
  assign req_d.op     = req_op_i;
  assign req_d.arga   = req_arga_i;
  assign req_d.argb   = req_argb_i;
  assign req_d.target = req_target_i;

  spill_register #(
    .T (acc_req_t)
  ) i_spill_req (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (req_d),
    .valid_o (req_q_valid),
    .ready_i (req_q_ready),
    .data_o  (req_q)
  );

  // Target demux, ready from the selected side only
  assign to_local    = (req_q.target == TARGET_LOCAL);
  assign to_shared   = (req_q.target == TARGET_SHARED);
  assign req_q_ready = to_local ? mul_req.ready : sh_req_ready_i;

  assign mul_req.valid = req_q_valid & to_local;
  assign mul_req.id    = req_q.id;
  assign mul_req.op    = req_q.op;
  assign mul_req.arga  = req_q.arga;
  assign mul_req.argb  = req_q.argb;

  assign sh_req_valid_o = req_q_valid & to_shared;
  assign sh_req_id_o    = req_q.id;
  assign sh_req_op_o    = req_q.op;
  assign sh_req_arga_o  = req_q.arga;
  assign sh_req_argb_o  = req_q.argb;

  int_mul_unit i_int_mul_unit (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (mul_req),
    .resp_o (mul_resp)
  );

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  assign sh_resp.valid   = sh_resp_valid_i;
  assign sh_resp.id      = sh_resp_id_i;
  assign sh_resp.data    = sh_resp_data_i;
  assign sh_resp.error   = sh_resp_error_i;
  assign sh_resp_ready_o = sh_resp.ready;

  resp_arbiter i_resp_arbiter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .local_i  (mul_resp),
    .shared_i (sh_resp),
    .resp_o   (arb_resp),
    .valid_o  (arb_valid),
    .ready_i  (arb_ready)
  );

  spill_register #(
    .T (acc_resp_t)
  ) i_spill_resp (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .data_i  (arb_resp),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i),
    .data_o  (resp_q)
  );

  assign resp_id_o    = resp_q.id;
  assign resp_data_o  = resp_q.data;
  assign resp_error_o = resp_q.error;

endmodule

//--- int_mul_unit.sv
/* Iterative integer multiplier
   MUL and MULHU behind request and response streams, one in flight */
`timescale 1ns/100ps

module int_mul_unit (
  input  logic    clk_i,
  input  logic    rst_i,
  acc_req_if.dst  req_i,
  acc_resp_if.src resp_o
);
  import offload_pkg::*;
  import mul_pkg::*;

  logic      load;
  logic      step;
  logic      last;
  acc_resp_t result;

  mul_ctrl i_mul_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_i.valid),
    .req_ready_o  (req_i.ready),
    .last_i       (last),
    .resp_ready_i (resp_o.ready),
    .resp_valid_o (resp_o.valid),
    .load_o       (load),
    .step_o       (step)
  );

  // Restarts from zero on every new operation
  mul_counter i_mul_counter (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clear_i (load),
    .en_i    (step),
    .last_o  (last)
  );

  mul_datapath #(
    .WIDTH (DATA_WIDTH)
  ) i_mul_datapath (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .load_i (load),
    .step_i (step),
    .id_i   (req_i.id),
    .op_i   (mul_op_e'(req_i.op)),
    .arga_i (req_i.arga),
    .argb_i (req_i.argb),
    .resp_o (result)
  );

  assign resp_o.id    = result.id;
  assign resp_o.data  = result.data;
  assign resp_o.error = result.error;

endmodule

//--- mul_datapath.sv
/* Multiplier datapath
   Shift-add product registers and low/high word selection */
`timescale 1ns/100ps

module mul_datapath #(
  parameter int WIDTH = offload_pkg::DATA_WIDTH
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            load_i,
  input  logic                            step_i,
  input  logic [offload_pkg::ID_WIDTH-1:0] id_i,
  input  mul_pkg::mul_op_e                op_i,
  input  logic [WIDTH-1:0]                arga_i,
  input  logic [WIDTH-1:0]                argb_i,
  output offload_pkg::acc_resp_t          resp_o
);
  import offload_pkg::*;
  import mul_pkg::*;

  logic [ID_WIDTH-1:0]  id_q;
  mul_op_e              op_q;
  logic [2*WIDTH-1:0]   mcand_q;
  logic [WIDTH-1:0]     mplier_q;
  logic [2*WIDTH-1:0]   acc_q;
  logic [WIDTH-1:0]     word;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      id_q     <= '0;
      op_q     <= MUL_LO;
      mcand_q  <= '0;
      mplier_q <= '0;
      acc_q    <= '0;
    end else if (load_i) begin
      id_q     <= id_i;
      op_q     <= op_i;
      mcand_q  <= {{WIDTH{1'b0}}, arga_i};
      mplier_q <= argb_i;
      acc_q    <= '0;
    end else if (step_i) begin
      // Add partial product for the current multiplier bit
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // ----------------------------------------
  // Result selection
  // ----------------------------------------
  always_comb begin
    resp_o.id    = id_q;
    resp_o.error = 1'b0;
    word         = '0;
    case (op_q)
      MUL_LO: word = acc_q[WIDTH-1:0];
      MUL_HU: word = acc_q[2*WIDTH-1:WIDTH];
      default: resp_o.error = 1'b1;
    endcase
    resp_o.data = DATA_WIDTH'(word);
  end

endmodule

//--- mul_counter.sv
/* Multiplier step counter
   Counts shift-add steps and flags the final one */
`timescale 1ns/100ps

module mul_counter (
  input  logic clk_i,
  input  logic rst_i,
  input  logic clear_i,
  input  logic en_i,
  output logic last_o
);
  import mul_pkg::*;

  logic [STEP_WIDTH-1:0] count_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
    end else if (en_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign last_o = (count_q == STEP_WIDTH'(MUL_STEPS - 1));

endmodule

//--- mul_ctrl.sv
/* Multiplier control
   FSM for accept, iterate and deliver of one operation at a time */
`timescale 1ns/100ps

module mul_ctrl (
  input  logic clk_i,
  input  logic rst_i,
  input  logic req_valid_i,
  output logic req_ready_o,
  input  logic last_i,
  input  logic resp_ready_i,
  output logic resp_valid_o,
  output logic load_o,
  output logic step_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_e;

  state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        // Last step completes on this edge
        if (last_i) begin
          state_d = DONE;
        end
      end
      DONE: begin
        if (resp_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign req_ready_o  = (state_q == IDLE);
  assign load_o       = req_valid_i & (state_q == IDLE);
  assign step_o       = (state_q == BUSY);
  assign resp_valid_o = (state_q == DONE);

endmodule

//--- resp_arbiter.sv
/* Response arbiter
   Round-robin merge of the local and shared response streams */
`timescale 1ns/100ps

module resp_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_i,
  acc_resp_if.dst               local_i,
  acc_resp_if.dst               shared_i,
  output offload_pkg::acc_resp_t resp_o,
  output logic                  valid_o,
  input  logic                  ready_i
);
  import offload_pkg::*;

  // Set when the shared input has priority
  logic prio_shared_q;
  logic grant_shared;
  logic out_xfer;

  assign grant_shared = shared_i.valid & (~local_i.valid | prio_shared_q);

  assign valid_o  = local_i.valid | shared_i.valid;
  assign out_xfer = valid_o & ready_i;

  // Payload follows the grant
  always_comb begin
    if (grant_shared) begin
      resp_o.id    = shared_i.id;
      resp_o.data  = shared_i.data;
      resp_o.error = shared_i.error;
    end else begin
      resp_o.id    = local_i.id;
      resp_o.data  = local_i.data;
      resp_o.error = local_i.error;
    end
  end

  // Only the granted side sees ready
  assign local_i.ready  = ready_i & local_i.valid & ~grant_shared;
  assign shared_i.ready = ready_i & grant_shared;

  // ----------------------------------------
  // Priority flips on every transfer
  // ----------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      prio_shared_q <= 1'b0;
    end else if (out_xfer) begin
      prio_shared_q <= ~prio_shared_q;
    end
  end

endmodule

//--- spill_register.sv
/* Spill register
   Two-entry valid/ready stage, cuts the path in both directions */
`timescale 1ns/100ps

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic a_full_q, a_full_d;
  logic b_full_q, b_full_d;
  logic ready_q;
  logic in_xfer, out_xfer;
  logic load_a_in, load_a_from_b, load_b;
  T     a_data_q, b_data_q;

  assign in_xfer  = valid_i & ready_q;
  assign out_xfer = a_full_q & ready_i;

  // Next fill state, A is the head entry
  always_comb begin
    a_full_d      = a_full_q;
    b_full_d      = b_full_q;
    load_a_in     = 1'b0;
    load_a_from_b = 1'b0;
    load_b        = 1'b0;
    if (out_xfer) begin
      if (b_full_q) begin
        // Input is closed while B holds an item
        load_a_from_b = 1'b1;
        b_full_d      = 1'b0;
      end else if (in_xfer) begin
        load_a_in = 1'b1;
      end else begin
        a_full_d = 1'b0;
      end
    end else if (in_xfer) begin
      if (a_full_q) begin
        load_b   = 1'b1;
        b_full_d = 1'b1;
      end else begin
        load_a_in = 1'b1;
        a_full_d  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      // Registered ready, no path from ready_i
      ready_q  <= ~b_full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_a_in) begin
      a_data_q <= data_i;
    end else if (load_a_from_b) begin
      a_data_q <= b_data_q;
    end
    if (load_b) begin
      b_data_q <= data_i;
    end
  end

  assign ready_o = ready_q;
  assign valid_o = a_full_q;
  assign data_o  = a_data_q;

endmodule

//--- offload_if.sv
/* Offload stream interfaces
   Valid/ready request and response channels between the blocks */
`timescale 1ns/100ps

interface acc_req_if;
  import offload_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [ID_WIDTH-1:0]   id;
  logic [OP_WIDTH-1:0]   op;
  logic [DATA_WIDTH-1:0] arga;
  logic [DATA_WIDTH-1:0] argb;

  modport src (output valid, id, op, arga, argb, input ready);
  modport dst (input valid, id, op, arga, argb, output ready);
endinterface

interface acc_resp_if;
  import offload_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [ID_WIDTH-1:0]   id;
  logic [DATA_WIDTH-1:0] data;
  logic                  error;

  modport src (output valid, id, data, error, input ready);
  modport dst (input valid, id, data, error, output ready);
endinterface

//--- mul_pkg.sv
/* Integer multiplier definitions
   Operation codes and iteration count of the shift-add unit */
package mul_pkg;

  // Supported operations, other codes answer with the error bit
  typedef enum logic [offload_pkg::OP_WIDTH-1:0] {
    MUL_LO = 0,
    MUL_HU = 1
  } mul_op_e;

  // One step per multiplier bit
  localparam int MUL_STEPS  = 32;
  localparam int STEP_WIDTH = $clog2(MUL_STEPS);

endpackage

//--- offload_pkg.sv
/* Offload path definitions
   Field widths, request and response structs and target codes */
package offload_pkg;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 5;
  localparam int OP_WIDTH   = 2;

  // Target bit values, steer a request to the local or shared unit
  localparam logic TARGET_LOCAL  = 1'b0;
  localparam logic TARGET_SHARED = 1'b1;

  // ----------------------------------------
  // Stream payloads
  // ----------------------------------------

  // Request from the core, 72 bits
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [OP_WIDTH-1:0]   op;
    logic [DATA_WIDTH-1:0] arga;
    logic [DATA_WIDTH-1:0] argb;
    logic                  target;
  } acc_req_t;

  // Response back to the core, 38 bits
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    logic                  error;
  } acc_resp_t;

endpackage
